/* build.f */
hw/dma_pkg.sv
hw/dma_fifo.sv
hw/dma_mem_port.sv
hw/dma_ctrl.sv
hw/dma_top.sv
tb/tb_wb_mem.sv
tb/tb_dma.sv

/* tb/tb_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma
  import dma_pkg::*;
();

  // Sum of count * 2 * (max_wait + 3) over all transfers, plus slack
  localparam int TIMEOUT_CYCLES =
    8 * 2 * (0 + 3) + 21 * 2 * (3 + 3) + 12 * 2 * (1 + 3) + 2 * 6 * 2 * (2 + 3) + 200;

  logic   clk;
  logic   rst;
  logic   start;
  dir_e   dir;
  addr_t  int_base, int_step, ext_base, ext_step;
  count_t count;
  logic   busy, done;
  logic   int_cyc, int_stb, int_we, int_ack;
  addr_t  int_adr;
  data_t  int_dat_w, int_dat_r;
  logic   ext_cyc, ext_stb, ext_we, ext_ack;
  addr_t  ext_adr;
  data_t  ext_dat_w, ext_dat_r;

  data_t  exp_int [0:65535];  // Expected internal memory
  data_t  exp_ext [0:65535];  // Expected external memory
  int     cycle_cnt = 0;
  int     done_cnt = 0;       // Done pulses since prepare_mems
  int     cyc_seen = 0;       // Cycles with any bus cycle open

  dma_top DUT (
    .clk(clk), .rst(rst), .start(start), .dir(dir),
    .int_base(int_base), .int_step(int_step), .ext_base(ext_base), .ext_step(ext_step),
    .count(count), .busy(busy), .done(done),
    .int_cyc(int_cyc), .int_stb(int_stb), .int_we(int_we), .int_adr(int_adr),
    .int_dat_w(int_dat_w), .int_dat_r(int_dat_r), .int_ack(int_ack),
    .ext_cyc(ext_cyc), .ext_stb(ext_stb), .ext_we(ext_we), .ext_adr(ext_adr),
    .ext_dat_w(ext_dat_w), .ext_dat_r(ext_dat_r), .ext_ack(ext_ack)
  );

  tb_wb_mem u_int_mem (
    .clk(clk), .rst(rst), .cyc(int_cyc), .stb(int_stb), .we(int_we), .adr(int_adr),
    .dat_w(int_dat_w), .dat_r(int_dat_r), .ack(int_ack)
  );

  tb_wb_mem u_ext_mem (
    .clk(clk), .rst(rst), .cyc(ext_cyc), .stb(ext_stb), .we(ext_we), .adr(ext_adr),
    .dat_w(ext_dat_w), .dat_r(ext_dat_r), .ack(ext_ack)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Bus activity and done pulses, sampled away from the rising edge
  always @(negedge clk)
  begin
    if (int_cyc || ext_cyc)
      cyc_seen++;
    if (done)
      done_cnt++;
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
      abort_run("Timeout, the DUT did not finish the transfers in time");
  end

  // ------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
    else
      abort_run($sformatf("FAIL at %0t ns: %s got 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
  endtask

  task automatic check_word(input string mem_name, input int a, input data_t got,
                            input data_t exp);
    assert (got == exp)
    else
      abort_run($sformatf("FAIL at %0t ns: %s[0x%04h] got 0x%04h, expected 0x%04h",
                          $time, mem_name, a, got, exp));
  endtask

  // Whole-memory compare on both buses
  task automatic compare_mems();
    int a;
    for (a = 0; a < 65536; a++)
    begin
      check_word("int_mem", a, u_int_mem.mem[a], exp_int[a]);
      check_word("ext_mem", a, u_ext_mem.mem[a], exp_ext[a]);
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic configure(input dir_e d, input addr_t ib, input addr_t istep,
                           input addr_t eb, input addr_t estep, input count_t n,
                           input int mw);
    @(negedge clk);
    dir      = d;
    int_base = ib;
    int_step = istep;
    ext_base = eb;
    ext_step = estep;
    count    = n;
    u_int_mem.max_wait = mw;
    u_ext_mem.max_wait = mw;
  endtask

  // Random fill, markers, and the expected image from the current config
  task automatic prepare_mems();
    int a;
    int k;
    done_cnt = 0;
    cyc_seen = 0;
    for (a = 0; a < 65536; a++)
    begin
      u_int_mem.mem[a] = data_t'($urandom);
      u_ext_mem.mem[a] = data_t'($urandom);
    end
    if (dir == DIR_INT_TO_EXT)
    begin
      u_ext_mem.mem[addr_t'(ext_base - ext_step)]         = 16'hdead;  // Just below
      u_ext_mem.mem[addr_t'(ext_base + count * ext_step)] = 16'hdead;  // Just above
    end
    else
    begin
      u_int_mem.mem[addr_t'(int_base - int_step)]         = 16'hdead;
      u_int_mem.mem[addr_t'(int_base + count * int_step)] = 16'hdead;
    end
    for (a = 0; a < 65536; a++)
    begin
      exp_int[a] = u_int_mem.mem[a];
      exp_ext[a] = u_ext_mem.mem[a];
    end
    // Word k from source base + k*step to destination base + k*step
    for (k = 0; k < count; k++)
    begin
      if (dir == DIR_INT_TO_EXT)
        exp_ext[addr_t'(ext_base + k * ext_step)] = exp_int[addr_t'(int_base + k * int_step)];
      else
        exp_int[addr_t'(int_base + k * int_step)] = exp_ext[addr_t'(ext_base + k * ext_step)];
    end
  endtask

  // Called on a falling edge
  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value("busy", busy, 1'b1);  // High one cycle after start
  endtask

  // Negedges from the one where start drops until done shows
  task automatic wait_done(output int cycles);
    cycles = 1;
    while (!done)
    begin
      @(negedge clk);
      cycles++;
    end
    check_value("busy", busy, 1'b0);  // Falls with done
    @(negedge clk);
    check_value("done", done, 1'b0);  // Single-cycle pulse
  endtask

  task automatic transfer(input dir_e d, input addr_t ib, input addr_t istep,
                          input addr_t eb, input addr_t estep, input count_t n,
                          input int mw);
    int cycles;
    configure(d, ib, istep, eb, estep, n, mw);
    prepare_mems();
    pulse_start();
    wait_done(cycles);
    check_value("done_cnt", done_cnt, 1);
    compare_mems();
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic check_reset();
    int i;
    for (i = 0; i < 8; i++)
    begin
      @(negedge clk);
      check_value("{int_cyc,int_stb,int_we,ext_cyc,ext_stb,ext_we,busy,done}",
                  {int_cyc, int_stb, int_we, ext_cyc, ext_stb, ext_we, busy, done}, 0);
    end
    rst = 1'b0;
    @(negedge clk);
    check_value("{int_cyc,int_stb,int_we,ext_cyc,ext_stb,ext_we,busy,done}",
                {int_cyc, int_stb, int_we, ext_cyc, ext_stb, ext_we, busy, done}, 0);
  endtask

  task automatic zero_count_run();
    int cycles;
    configure(DIR_INT_TO_EXT, 16'h0400, 16'h0001, 16'h0500, 16'h0001, 16'd0, 0);
    prepare_mems();
    pulse_start();
    wait_done(cycles);
    check_value("done latency", cycles, 2);
    check_value("cyc_seen", cyc_seen, 0);  // No bus traffic at all
    check_value("done_cnt", done_cnt, 1);
    check_value("busy", busy, 1'b0);
    compare_mems();
  endtask

  task automatic ignore_start_while_busy();
    int cycles;
    configure(DIR_INT_TO_EXT, 16'h0200, 16'h0001, 16'h0300, 16'h0002, 16'd12, 1);
    prepare_mems();
    pulse_start();
    repeat (4) @(negedge clk);
    // Other direction and range, mid-transfer
    configure(DIR_EXT_TO_INT, 16'h0600, 16'h0001, 16'h0700, 16'h0001, 16'd3, 1);
    pulse_start();
    wait_done(cycles);
    repeat (10) @(negedge clk);  // Room for a stray second run
    check_value("done_cnt", done_cnt, 1);
    check_value("busy", busy, 1'b0);
    compare_mems();
  endtask

  task automatic wrap_then_reverse();
    transfer(DIR_INT_TO_EXT, 16'h0100, 16'h0001, 16'hfffd, 16'h0001, 16'd6, 2);
    check_word("ext_mem", 0, u_ext_mem.mem[0], u_int_mem.mem[16'h0103]);  // Word 3 wraps
    transfer(DIR_EXT_TO_INT, 16'h0040, 16'h0001, 16'hfffe, 16'h0002, 16'd6, 2);
  endtask

  initial
  begin
    void'($urandom(32'heb963753));
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    dir      = DIR_INT_TO_EXT;
    int_base = '0;
    int_step = '0;
    ext_base = '0;
    ext_step = '0;
    count    = '0;
    check_reset();
    transfer(DIR_INT_TO_EXT, 16'h0010, 16'h0001, 16'h0080, 16'h0001, 16'd8, 0);
    transfer(DIR_EXT_TO_INT, 16'h1000, 16'h0003, 16'h2000, 16'h0001, 16'd21, 3);
    zero_count_run();
    ignore_start_while_busy();
    wrap_then_reverse();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_wb_mem.sv */
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave memory, random ack delay per request
module tb_wb_mem
  import dma_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        cyc,
  input  wire        stb,
  input  wire        we,
  input  wire addr_t adr,
  input  wire data_t dat_w,
  output data_t      dat_r,
  output logic       ack
);

  data_t mem [0:65535];  // Filled by the testbench
  int    max_wait = 0;   // Longest extra wait, 0 acks in the next cycle
  logic  pending;        // Delay already drawn for this request
  int    left;           // Wait cycles still to go

  assign dat_r = mem[adr];  // Master samples it with ack

  // ------------------------------------------------------------
  // Request handling
  // ------------------------------------------------------------
  always @(posedge clk or posedge rst)
  begin : respond
    int w;
    if (rst)
    begin
      ack     <= 1'b0;
      pending <= 1'b0;
      left    <= 0;
    end
    else
    begin
      ack <= 1'b0;  // One-cycle ack
      if (cyc && stb && !ack)
      begin
        w = pending ? left : $urandom_range(max_wait, 0);
        if (w == 0)
        begin
          ack     <= 1'b1;
          pending <= 1'b0;
          if (we)
            mem[adr] <= dat_w;  // Write lands with ack
        end
        else
        begin
          pending <= 1'b1;
          left    <= w - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Single-channel DMA, internal bus <-> FIFO <-> external bus
module dma_top
  import dma_pkg::*;
#(
  parameter int FIFO_AW = FIFO_AW_DEFAULT
)
(
  input  wire         clk,
  input  wire         rst,
  // Control
  input  wire         start,
  input  wire dir_e   dir,
  input  wire addr_t  int_base,
  input  wire addr_t  int_step,
  input  wire addr_t  ext_base,
  input  wire addr_t  ext_step,
  input  wire count_t count,
  output logic        busy,
  output logic        done,
  // Internal Wishbone master
  output logic        int_cyc,
  output logic        int_stb,
  output logic        int_we,
  output addr_t       int_adr,
  output data_t       int_dat_w,
  input  wire data_t  int_dat_r,
  input  wire         int_ack,
  // External Wishbone master
  output logic        ext_cyc,
  output logic        ext_stb,
  output logic        ext_we,
  output addr_t       ext_adr,
  output data_t       ext_dat_w,
  input  wire data_t  ext_dat_r,
  input  wire         ext_ack
);

  // ------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------
  logic  int_start, ext_start;
  logic  int_is_source, ext_is_source;
  logic  int_ready, ext_ready;
  logic  int_take, ext_take;
  logic  int_done, ext_done;
  data_t int_rd_word, ext_rd_word;
  logic  push, pop, empty, full;
  data_t push_data;
  data_t head;  // Shared write word for both ports

  dma_ctrl u_ctrl (
    .clk(clk), .rst(rst), .start(start), .dir(dir), .busy(busy), .done(done),
    .int_start(int_start), .ext_start(ext_start),
    .int_is_source(int_is_source), .ext_is_source(ext_is_source),
    .int_ready(int_ready), .ext_ready(ext_ready),
    .int_take(int_take), .ext_take(ext_take),
    .int_rd_word(int_rd_word), .ext_rd_word(ext_rd_word),
    .int_done(int_done), .ext_done(ext_done),
    .push(push), .push_data(push_data), .pop(pop), .empty(empty), .full(full)
  );

  dma_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
    .clk(clk), .rst(rst), .push(push), .push_data(push_data), .pop(pop),
    .head(head), .empty(empty), .full(full)
  );

  // Internal side
  dma_mem_port u_int_port (
    .clk(clk), .rst(rst), .start_port(int_start), .is_source(int_is_source),
    .base(int_base), .step(int_step), .count(count),
    .ready(int_ready), .wr_word(head),
    .take(int_take), .rd_word(int_rd_word), .done_port(int_done),
    .cyc(int_cyc), .stb(int_stb), .we(int_we), .adr(int_adr), .dat_w(int_dat_w),
    .dat_r(int_dat_r), .ack(int_ack)
  );

  // External side
  dma_mem_port u_ext_port (
    .clk(clk), .rst(rst), .start_port(ext_start), .is_source(ext_is_source),
    .base(ext_base), .step(ext_step), .count(count),
    .ready(ext_ready), .wr_word(head),
    .take(ext_take), .rd_word(ext_rd_word), .done_port(ext_done),
    .cyc(ext_cyc), .stb(ext_stb), .we(ext_we), .adr(ext_adr), .dat_w(ext_dat_w),
    .dat_r(ext_dat_r), .ack(ext_ack)
  );

endmodule

`default_nettype wire

/* hw/dma_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Run sequencing and FIFO routing between the two ports
module dma_ctrl
  import dma_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        start,
  input  wire dir_e  dir,
  output logic       busy,
  output logic       done,
  output logic       int_start,
  output logic       ext_start,
  output logic       int_is_source,
  output logic       ext_is_source,
  output logic       int_ready,
  output logic       ext_ready,
  input  wire        int_take,
  input  wire        ext_take,
  input  wire data_t int_rd_word,
  input  wire data_t ext_rd_word,
  input  wire        int_done,
  input  wire        ext_done,
  output logic       push,
  output data_t      push_data,
  output logic       pop,
  input  wire        empty,
  input  wire        full
);

  typedef enum logic {
    CTRL_IDLE,
    CTRL_RUN
  } ctrl_state_e;

  ctrl_state_e state;
  dir_e        dir_r;    // Direction of the current run
  dir_e        cur_dir;
  logic        accept;   // Start taken this cycle
  logic        finish;
  logic        running;

  assign running = (state == CTRL_RUN);
  assign accept  = start && !running;  // Ignored while busy
  assign finish  = running && int_done && ext_done && empty;

  // Live dir in idle so ports latch the right role with start_port
  assign cur_dir = running ? dir_r : dir;

  // ------------------------------------------------------------
  // Run state and done pulse
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= CTRL_IDLE;
      dir_r <= DIR_INT_TO_EXT;
      done  <= 1'b0;
    end
    else
    begin
      done <= finish;  // One cycle, busy falls with it
      if (accept)
      begin
        state <= CTRL_RUN;
        dir_r <= dir;
      end
      else if (finish)
        state <= CTRL_IDLE;
    end
  end

  assign busy = running;

  // Both ports load in the accept cycle
  assign int_start = accept;
  assign ext_start = accept;

  assign int_is_source = (cur_dir == DIR_INT_TO_EXT);
  assign ext_is_source = (cur_dir == DIR_EXT_TO_INT);

  // ------------------------------------------------------------
  // FIFO routing
  // ------------------------------------------------------------
  assign int_ready = int_is_source ? !full : !empty;  // Room to read / word to write
  assign ext_ready = ext_is_source ? !full : !empty;

  assign push      = running && (int_is_source ? int_take : ext_take);
  assign pop       = running && (int_is_source ? ext_take : int_take);
  assign push_data = int_is_source ? int_rd_word : ext_rd_word;

endmodule

`default_nettype wire

/* hw/dma_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

// Address generator and Wishbone classic master for one bus
// Source role reads into the FIFO and destination role writes from it
module dma_mem_port
  import dma_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         start_port,  // Load pulse from controller
  input  wire         is_source,
  input  wire addr_t  base,
  input  wire addr_t  step,
  input  wire count_t count,
  input  wire         ready,       // FIFO not full or not empty
  input  wire data_t  wr_word,     // FIFO head
  output logic        take,
  output data_t       rd_word,
  output logic        done_port,
  output logic        cyc,
  output logic        stb,
  output logic        we,
  output addr_t       adr,
  output data_t       dat_w,
  input  wire data_t  dat_r,
  input  wire         ack
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT,  // Words left and waiting on FIFO
    PORT_BUS,   // Cycle open and waiting on ack
    PORT_DONE
  } port_state_e;

  port_state_e state;
  logic        src_r;    // Latched role
  count_t      remain;   // Words still to move
  addr_t       idx;      // Current word address
  addr_t       step_r;   // Modifier
  data_t       wdata_r;  // Word being written
  logic        issue;
  logic        finish;

  assign issue  = (state == PORT_WAIT) && ready;  // Open a cycle next edge
  assign finish = (state == PORT_BUS) && ack;     // Slave done with this word

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state  <= PORT_IDLE;
      src_r  <= 1'b0;
      remain <= '0;
    end
    else if (start_port)
    begin
      src_r  <= is_source;
      remain <= count;
      state  <= (count == '0) ? PORT_DONE : PORT_WAIT;  // Empty transfer ends at once
    end
    else
    begin
      case (state)
        PORT_WAIT:
          if (ready)
            state <= PORT_BUS;
        PORT_BUS:
          if (ack)
          begin
            remain <= remain - count_t'(1);
            // Last word goes straight to done
            state  <= (remain == count_t'(1)) ? PORT_DONE : PORT_WAIT;
          end
        default:
          state <= state;  // Idle and done hold until start_port
      endcase
    end
  end

  // Address stepping
  always_ff @(posedge clk)
  begin
    if (start_port)
    begin
      idx    <= base;
      step_r <= step;
    end
    else if (finish)
      idx <= idx + step_r;  // Modulo 2^16
  end

  // Capture FIFO head as it is popped
  always_ff @(posedge clk)
  begin
    if (issue && !src_r)
      wdata_r <= wr_word;
  end

  // ------------------------------------------------------------
  // Bus and FIFO side outputs
  // ------------------------------------------------------------
  assign cyc   = (state == PORT_BUS);
  assign stb   = (state == PORT_BUS);       // Raised together with cyc
  assign we    = (state == PORT_BUS) && !src_r;
  assign adr   = idx;
  assign dat_w = we ? wdata_r : '0;         // Low when not writing

  // Pop at issue as destination and push at ack as source
  assign take      = src_r ? finish : issue;
  assign rd_word   = (src_r && finish) ? dat_r : '0;
  assign done_port = (state == PORT_DONE);

endmodule

`default_nettype wire

/* hw/dma_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Show-ahead FIFO where head always holds the oldest word
module dma_fifo
  import dma_pkg::*;
#(
  parameter int FIFO_AW = 3
)
(
  input  wire        clk,
  input  wire        rst,
  input  wire        push,
  input  wire data_t push_data,
  input  wire        pop,
  output data_t      head,
  output logic       empty,
  output logic       full
);

  localparam int DEPTH = 2 ** FIFO_AW;

  data_t              mem [DEPTH];  // Word storage
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   cnt;          // One bit wider than the pointers
  logic               do_push;
  logic               do_pop;

  // Guarded strobes
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (cnt == '0);
  assign full  = cnt[FIFO_AW];  // Top bit set only at DEPTH
  assign head  = mem[rd_ptr];   // Show-ahead read

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // Both or neither
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* hw/dma_pkg.sv */
`default_nettype none

// ------------------------------------------------------------
// Shared types for the single-channel DMA
// ------------------------------------------------------------
package dma_pkg;

  typedef logic [15:0] addr_t;   // Word address on either bus
  typedef logic [15:0] data_t;   // One transferred word
  typedef logic [15:0] count_t;  // Words per transfer, zero means none

  // Which bus feeds the FIFO
  typedef enum logic {
    DIR_INT_TO_EXT = 1'b0,  // Internal read, external write
    DIR_EXT_TO_INT = 1'b1   // External read, internal write
  } dir_e;

  // log2 of FIFO depth, 8 entries
  localparam int FIFO_AW_DEFAULT = 3;

endpackage

`default_nettype wire
